// File: verilog/isaPkg.sv
// MIPS instruction encoding
`default_nettype none

package isaPkg;

    // ------------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------------
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNC_W     = 6;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;
    localparam int TARGET_W   = 26;
    localparam int NUM_REGS   = 32;

    typedef logic [WORD_W-1:0]     wordT;
    typedef logic [REG_ADDR_W-1:0] regAddrT;
    typedef logic [OPCODE_W-1:0]   opcodeT;
    typedef logic [FUNC_W-1:0]     funcT;
    typedef logic [SHAMT_W-1:0]    shamtT;

    // ------------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------------
    localparam opcodeT OP_RTYPE = 6'd0;
    localparam opcodeT OP_J     = 6'd2;
    localparam opcodeT OP_JAL   = 6'd3;
    localparam opcodeT OP_BEQ   = 6'd4;
    localparam opcodeT OP_BNE   = 6'd5;
    localparam opcodeT OP_ADDI  = 6'd8;
    localparam opcodeT OP_ADDIU = 6'd9;
    localparam opcodeT OP_SLTI  = 6'd10;
    localparam opcodeT OP_ANDI  = 6'd12;
    localparam opcodeT OP_ORI   = 6'd13;
    localparam opcodeT OP_XORI  = 6'd14;
    localparam opcodeT OP_LUI   = 6'd15;
    localparam opcodeT OP_LW    = 6'd35;
    localparam opcodeT OP_SW    = 6'd43;

    // R-type function codes
    localparam funcT FN_SLL  = 6'd0;
    localparam funcT FN_SRL  = 6'd2;
    localparam funcT FN_SRA  = 6'd3;
    localparam funcT FN_JR   = 6'd8;
    localparam funcT FN_ADD  = 6'd32;
    localparam funcT FN_ADDU = 6'd33;
    localparam funcT FN_SUB  = 6'd34;
    localparam funcT FN_SUBU = 6'd35;
    localparam funcT FN_AND  = 6'd36;
    localparam funcT FN_OR   = 6'd37;
    localparam funcT FN_XOR  = 6'd38;
    localparam funcT FN_NOR  = 6'd39;
    localparam funcT FN_SLT  = 6'd42;

    // Return address register
    localparam regAddrT RA_ADDR = 5'd31;

endpackage

`default_nettype wire

// File: verilog/pipePkg.sv
// Pipeline control bundles
`default_nettype none

package pipePkg;

    import isaPkg::*;

    // ------------------------------------------------------------------
    // Execute and memory operation codes
    // ------------------------------------------------------------------
    typedef logic [3:0] aluOpT;
    typedef logic [2:0] memFuncT;
    typedef logic [1:0] immSelT;
    typedef logic [1:0] dstSelT;

    localparam aluOpT ALU_ADD  = 4'd0;
    localparam aluOpT ALU_ADDU = 4'd1;
    localparam aluOpT ALU_SUB  = 4'd2;
    localparam aluOpT ALU_SUBU = 4'd3;
    localparam aluOpT ALU_AND  = 4'd4;
    localparam aluOpT ALU_OR   = 4'd5;
    localparam aluOpT ALU_XOR  = 4'd6;
    localparam aluOpT ALU_NOR  = 4'd7;
    localparam aluOpT ALU_SLT  = 4'd8;
    localparam aluOpT ALU_SLL  = 4'd9;
    localparam aluOpT ALU_SRL  = 4'd10;
    localparam aluOpT ALU_SRA  = 4'd11;

    localparam memFuncT MEM_NONE = 3'd0;
    localparam memFuncT MEM_WORD = 3'd2;

    localparam immSelT IMM_SIGN  = 2'd0;
    localparam immSelT IMM_ZERO  = 2'd1;
    localparam immSelT IMM_UPPER = 2'd2;
    localparam immSelT IMM_JUMP  = 2'd3;

    localparam dstSelT DST_RT = 2'd0;
    localparam dstSelT DST_RD = 2'd1;
    localparam dstSelT DST_RA = 2'd2;

    // ------------------------------------------------------------------
    // Stage bundles
    // ------------------------------------------------------------------
    typedef struct packed {
        logic       branch;
        logic       jump;
        logic       regJump;
        logic       memRead;
        logic       memWrite;
        logic       memToReg;
        logic       aluSrc;
        logic       regWrite;
        logic       illegal;
        aluOpT      aluOp;
        memFuncT    memFunc;
        logic [2:0] brCode;
    } ctrlT;

    typedef struct packed {
        ctrlT             ctrl;
        regAddrT          rsAddr;
        regAddrT          rtAddr;
        regAddrT          destAddr;
        shamtT            shamt;
        wordT             rsData;
        wordT             rtData;
        wordT             imm;
        logic [IMM_W-1:0] offset;
    } decodedT;

endpackage

`default_nettype wire

// File: verilog/instrLatch.sv
// Fetch to decode latch
`timescale 1ns/1ps
`default_nettype none

module instrLatch
    import isaPkg::*;
(
    input  wire  Clock,
    input  wire  arstN,
    input  wordT instr,
    input  wire  instrValid,
    output wordT idInstr,
    output logic idValid
);

    // Captures every edge, the strobe marks real instructions
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            idInstr <= '0;
            idValid <= 1'b0;
        end else begin
            idInstr <= instr;
            idValid <= instrValid;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ctrlDecoder.sv
// Opcode and function decoder
`timescale 1ns/1ps
`default_nettype none

module ctrlDecoder
    import isaPkg::*;
    import pipePkg::*;
(
    input  opcodeT opcode,
    input  funcT   func,
    input  wire    linkBit,
    output ctrlT   ctrl,
    output immSelT immSel,
    output dstSelT dstSel
);

    always_comb begin
        // Everything off unless the code is recognised
        ctrl   = '0;
        immSel = IMM_SIGN;
        dstSel = DST_RT;

        case (opcode)
            OP_RTYPE: begin
                dstSel        = DST_RD;
                ctrl.regWrite = 1'b1;
                case (func)
                    FN_ADD:  ctrl.aluOp = ALU_ADD;
                    FN_ADDU: ctrl.aluOp = ALU_ADDU;
                    FN_SUB:  ctrl.aluOp = ALU_SUB;
                    FN_SUBU: ctrl.aluOp = ALU_SUBU;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_XOR:  ctrl.aluOp = ALU_XOR;
                    FN_NOR:  ctrl.aluOp = ALU_NOR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    FN_SLL:  ctrl.aluOp = ALU_SLL;
                    FN_SRL:  ctrl.aluOp = ALU_SRL;
                    FN_SRA:  ctrl.aluOp = ALU_SRA;
                    FN_JR: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.regJump  = 1'b1;
                    end
                    default: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.illegal  = 1'b1;
                    end
                endcase
            end

            // ----------------------------------------------------------------
            // Immediate arithmetic
            // ----------------------------------------------------------------
            OP_ADDI, OP_ADDIU, OP_SLTI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = (opcode == OP_ADDI)  ? ALU_ADD  :
                                (opcode == OP_ADDIU) ? ALU_ADDU : ALU_SLT;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                immSel        = IMM_ZERO;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = (opcode == OP_ANDI) ? ALU_AND :
                                (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            OP_LUI: begin
                // rs is zero here, so the sum is the shifted immediate
                immSel        = IMM_UPPER;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = ALU_ADDU;
            end

            // Word loads and stores
            OP_LW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memFunc  = MEM_WORD;
            end
            OP_SW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.memFunc  = MEM_WORD;
            end

            OP_BEQ, OP_BNE: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = ALU_SUB;
                ctrl.brCode = opcode[2:0];
                if (linkBit) begin
                    dstSel = DST_RA;
                end
            end

            OP_J: begin
                immSel    = IMM_JUMP;
                ctrl.jump = 1'b1;
            end
            OP_JAL: begin
                immSel        = IMM_JUMP;
                dstSel        = DST_RA;
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/regFile.sv
// General purpose register file
`timescale 1ns/1ps
`default_nettype none

module regFile
    import isaPkg::*;
(
    input  wire     Clock,
    input  wire     arstN,
    input  wire     wbEn,
    input  regAddrT wbAddr,
    input  wordT    wbData,
    input  regAddrT rsAddr,
    input  regAddrT rtAddr,
    output wordT    rsData,
    output wordT    rtData
);

    wordT regs [NUM_REGS];

    // Register 0 is never written and stays zero
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (wbAddr != '0)) begin
            regs[wbAddr] <= wbData;
        end
    end

    // Asynchronous reads, no write bypass
    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

endmodule

`default_nettype wire

// File: verilog/decodeUnit.sv
// Instruction decode unit
`timescale 1ns/1ps
`default_nettype none

module decodeUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input  wire     Clock,
    input  wire     arstN,
    input  wordT    idInstr,
    input  wire     wbEn,
    input  regAddrT wbAddr,
    input  wordT    wbData,
    output decodedT idBundle
);

    regAddrT             rsAddr;
    regAddrT             rtAddr;
    regAddrT             rdAddr;
    logic [IMM_W-1:0]    offset;
    logic [TARGET_W-1:0] target;
    ctrlT                ctrl;
    immSelT              immSel;
    dstSelT              dstSel;
    wordT                rsData;
    wordT                rtData;
    wordT                imm;
    regAddrT             destAddr;

    assign rsAddr = idInstr[25:21];
    assign rtAddr = idInstr[20:16];
    assign rdAddr = idInstr[15:11];
    assign offset = idInstr[15:0];
    assign target = idInstr[25:0];

    ctrlDecoder ctrlDecoder_inst (
        .opcode (idInstr[31:26]),
        .func   (idInstr[5:0]),
        .linkBit(rtAddr[4]),
        .ctrl   (ctrl),
        .immSel (immSel),
        .dstSel (dstSel)
    );

    regFile regFile_inst (
        .Clock (Clock),
        .arstN (arstN),
        .wbEn  (wbEn),
        .wbAddr(wbAddr),
        .wbData(wbData),
        .rsAddr(rsAddr),
        .rtAddr(rtAddr),
        .rsData(rsData),
        .rtData(rtData)
    );

    // ------------------------------------------------------------------
    // Immediate and destination selection
    // ------------------------------------------------------------------
    always_comb begin
        case (immSel)
            IMM_ZERO:  imm = {{(WORD_W-IMM_W){1'b0}}, offset};
            IMM_UPPER: imm = {offset, {(WORD_W-IMM_W){1'b0}}};
            IMM_JUMP:  imm = {{(WORD_W-TARGET_W){1'b0}}, target};
            default:   imm = {{(WORD_W-IMM_W){offset[IMM_W-1]}}, offset};
        endcase

        case (dstSel)
            DST_RD:  destAddr = rdAddr;
            DST_RA:  destAddr = RA_ADDR;
            default: destAddr = rtAddr;
        endcase
    end

    always_comb begin
        idBundle.ctrl     = ctrl;
        idBundle.rsAddr   = rsAddr;
        idBundle.rtAddr   = rtAddr;
        idBundle.destAddr = destAddr;
        idBundle.shamt    = idInstr[10:6];
        idBundle.rsData   = rsData;
        idBundle.rtData   = rtData;
        idBundle.imm      = imm;
        idBundle.offset   = offset;
    end

endmodule

`default_nettype wire

// File: verilog/idExReg.sv
// Decode to execute register
`timescale 1ns/1ps
`default_nettype none

module idExReg
    import pipePkg::*;
(
    input  wire     Clock,
    input  wire     arstN,
    input  decodedT idBundle,
    input  wire     idValid,
    output decodedT exBundle,
    output logic    exValid
);

    decodedT gatedBundle;

    // A bubble keeps its data but loses every control bit
    always_comb begin
        gatedBundle = idBundle;
        if (!idValid) begin
            gatedBundle.ctrl = '0;
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            exBundle <= '0;
            exValid  <= 1'b0;
        end else begin
            exBundle <= gatedBundle;
            exValid  <= idValid;
        end
    end

endmodule

`default_nettype wire

// File: verilog/decodeTop.sv
// Decode stage top level
`timescale 1ns/1ps
`default_nettype none

module decodeTop
    import isaPkg::*;
    import pipePkg::*;
(
    input  wire     Clock,
    input  wire     arstN,
    input  wordT    instr,
    input  wire     instrValid,
    input  wire     wbEn,
    input  regAddrT wbAddr,
    input  wordT    wbData,
    output logic    exValid,
    output decodedT exBundle
);

    wordT    idInstr;
    logic    idValid;
    decodedT idBundle;

    instrLatch instrLatch_inst (
        .Clock     (Clock),
        .arstN     (arstN),
        .instr     (instr),
        .instrValid(instrValid),
        .idInstr   (idInstr),
        .idValid   (idValid)
    );

    decodeUnit decodeUnit_inst (
        .Clock   (Clock),
        .arstN   (arstN),
        .idInstr (idInstr),
        .wbEn    (wbEn),
        .wbAddr  (wbAddr),
        .wbData  (wbData),
        .idBundle(idBundle)
    );

    idExReg idExReg_inst (
        .Clock   (Clock),
        .arstN   (arstN),
        .idBundle(idBundle),
        .idValid (idValid),
        .exBundle(exBundle),
        .exValid (exValid)
    );

endmodule

`default_nettype wire

// File: verification/decodeCheck_assert.sv
// Decode output rule checks
`timescale 1ns/1ps
`default_nettype none

module decodeCheck_assert
    import pipePkg::*;
(
    input wire     Clock,
    input wire     arstN,
    input wire     exValid,
    input decodedT exBundle
);

    // Held in reset, the output register stays clear
    resetClear: assert property (@(posedge Clock) !arstN |=> (!exValid && exBundle == '0))
        else $error("output register not clear while reset is held");

    bubbleCtrl: assert property (@(posedge Clock) disable iff (!arstN)
        !exValid |-> (exBundle.ctrl == '0))
        else $error("bubble carries control bits");

    // Register 0 always reads zero
    zeroRs: assert property (@(posedge Clock) disable iff (!arstN)
        (exBundle.rsAddr == '0) |-> (exBundle.rsData == '0))
        else $error("register 0 read nonzero on rs");

    zeroRt: assert property (@(posedge Clock) disable iff (!arstN)
        (exBundle.rtAddr == '0) |-> (exBundle.rtData == '0))
        else $error("register 0 read nonzero on rt");

endmodule

bind decodeTop decodeCheck_assert decodeCheck_assert_inst (
    .Clock   (Clock),
    .arstN   (arstN),
    .exValid (exValid),
    .exBundle(exBundle)
);

`default_nettype wire

// File: verification/decodeTb.sv
// Decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module decodeTb
    import isaPkg::*;
    import pipePkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_ROWS     = 19;
    // Reset, register preload and drain, plus four cycles per row
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_REGS + 8 + NUM_ROWS * 4;

    // Flags are branch jump regJump memRead memWrite memToReg aluSrc regWrite
    typedef struct packed {
        wordT       instr;
        logic       valid;
        aluOpT      aluOp;
        logic [7:0] flags;
        logic [2:0] brCode;
        wordT       imm;
        regAddrT    dest;
        logic       illegal;
    } rowT;

    logic    Clock;
    logic    arstN;
    wordT    instr;
    logic    instrValid;
    logic    wbEn;
    regAddrT wbAddr;
    wordT    wbData;
    logic    exValid;
    decodedT exBundle;

    rowT    rows [NUM_ROWS];
    string  rowName [NUM_ROWS];
    int     rowCount;
    wordT   model [NUM_REGS];
    integer seed;
    int     checkCount;
    int     errCount;

    decodeTop decodeTop_inst (
        .Clock     (Clock),
        .arstN     (arstN),
        .instr     (instr),
        .instrValid(instrValid),
        .wbEn      (wbEn),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .exValid   (exValid),
        .exBundle  (exBundle)
    );

    initial begin
        Clock = 1'b0;
        forever #(CLK_PERIOD / 2) Clock = ~Clock;
    end

    // ------------------------------------------------------------------
    // Instruction builders and immediate rules
    // ------------------------------------------------------------------
    function automatic wordT rType(regAddrT rs, regAddrT rt, regAddrT rd, shamtT sh, funcT fn);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic wordT iType(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] imm16);
        return {op, rs, rt, imm16};
    endfunction

    function automatic wordT jType(opcodeT op, logic [25:0] target);
        return {op, target};
    endfunction

    function automatic wordT signExt(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic wordT zeroExt(logic [15:0] v);
        return {16'h0000, v};
    endfunction

    task automatic addRow(input string name, input wordT ins, input logic valid,
                          input aluOpT aluOp, input logic [7:0] flags, input logic [2:0] brCode,
                          input wordT imm, input regAddrT dest, input logic illegal);
        rows[rowCount]    = {ins, valid, aluOp, flags, brCode, imm, dest, illegal};
        rowName[rowCount] = name;
        rowCount++;
    endtask

    task automatic buildTable();
        addRow("add", rType(5'd3, 5'd4, 5'd5, 5'd0, FN_ADD), 1'b1, ALU_ADD, 8'h01, 3'd0,
               signExt({5'd5, 5'd0, FN_ADD}), 5'd5, 1'b0);
        addRow("subu", rType(5'd7, 5'd8, 5'd6, 5'd0, FN_SUBU), 1'b1, ALU_SUBU, 8'h01, 3'd0,
               signExt({5'd6, 5'd0, FN_SUBU}), 5'd6, 1'b0);
        addRow("nor", rType(5'd10, 5'd11, 5'd9, 5'd0, FN_NOR), 1'b1, ALU_NOR, 8'h01, 3'd0,
               signExt({5'd9, 5'd0, FN_NOR}), 5'd9, 1'b0);
        addRow("slt", rType(5'd13, 5'd14, 5'd12, 5'd0, FN_SLT), 1'b1, ALU_SLT, 8'h01, 3'd0,
               signExt({5'd12, 5'd0, FN_SLT}), 5'd12, 1'b0);
        addRow("sra", rType(5'd0, 5'd16, 5'd15, 5'd7, FN_SRA), 1'b1, ALU_SRA, 8'h01, 3'd0,
               signExt({5'd15, 5'd7, FN_SRA}), 5'd15, 1'b0);
        addRow("jr", rType(5'd31, 5'd0, 5'd0, 5'd0, FN_JR), 1'b1, ALU_ADD, 8'h20, 3'd0,
               signExt({5'd0, 5'd0, FN_JR}), 5'd0, 1'b0);
        addRow("addi", iType(OP_ADDI, 5'd1, 5'd2, 16'hFFF0), 1'b1, ALU_ADD, 8'h03, 3'd0,
               signExt(16'hFFF0), 5'd2, 1'b0);
        addRow("andi", iType(OP_ANDI, 5'd17, 5'd18, 16'h8001), 1'b1, ALU_AND, 8'h03, 3'd0,
               zeroExt(16'h8001), 5'd18, 1'b0);
        addRow("ori", iType(OP_ORI, 5'd19, 5'd20, 16'hF00F), 1'b1, ALU_OR, 8'h03, 3'd0,
               zeroExt(16'hF00F), 5'd20, 1'b0);
        addRow("lui", iType(OP_LUI, 5'd0, 5'd21, 16'h1234), 1'b1, ALU_ADDU, 8'h03, 3'd0,
               32'h1234_0000, 5'd21, 1'b0);
        addRow("lw", iType(OP_LW, 5'd22, 5'd23, 16'hFFF8), 1'b1, ALU_ADD, 8'h17, 3'd0,
               signExt(16'hFFF8), 5'd23, 1'b0);
        addRow("sw", iType(OP_SW, 5'd24, 5'd25, 16'h000C), 1'b1, ALU_ADD, 8'h0A, 3'd0,
               signExt(16'h000C), 5'd25, 1'b0);
        addRow("beq", iType(OP_BEQ, 5'd26, 5'd9, 16'hFFFC), 1'b1, ALU_SUB, 8'h80, 3'b100,
               signExt(16'hFFFC), 5'd9, 1'b0);
        addRow("bne", iType(OP_BNE, 5'd27, 5'd3, 16'h0010), 1'b1, ALU_SUB, 8'h80, 3'b101,
               signExt(16'h0010), 5'd3, 1'b0);
        // Bubble keeps its fields but no control
        addRow("bubble", iType(OP_ADDI, 5'd28, 5'd4, 16'h0005), 1'b0, ALU_ADD, 8'h00, 3'd0,
               signExt(16'h0005), 5'd4, 1'b0);
        addRow("j", jType(OP_J, 26'h0AB_CDEF), 1'b1, ALU_ADD, 8'h40, 3'd0,
               32'h00AB_CDEF, 5'd11, 1'b0);
        addRow("jal", jType(OP_JAL, 26'h000_0100), 1'b1, ALU_ADD, 8'h41, 3'd0,
               32'h0000_0100, RA_ADDR, 1'b0);
        addRow("bad opcode", iType(6'd63, 5'd29, 5'd30, 16'h1234), 1'b1, ALU_ADD, 8'h00, 3'd0,
               32'h0000_1234, 5'd30, 1'b1);
        addRow("bad func", rType(5'd30, 5'd3, 5'd3, 5'd0, 6'd1), 1'b1, ALU_ADD, 8'h00, 3'd0,
               signExt({5'd3, 5'd0, 6'd1}), 5'd3, 1'b1);
    endtask

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    task automatic checkValue(input string test, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
        checkCount++;
        assert (act === exp) else begin
            errCount++;
            $display("mismatch %s %s: expected %h, actual %h", test, what, exp, act);
        end
    endtask

    task automatic checkQuiet(input string test);
        checkValue(test, "exValid", 32'(1'b0), 32'(exValid));
        checkValue(test, "ctrl", 32'(0), 32'(exBundle.ctrl));
        checkValue(test, "rsData", 32'(0), exBundle.rsData);
        checkValue(test, "rtData", 32'(0), exBundle.rtData);
    endtask

    task automatic checkRow(input int idx);
        rowT        row;
        ctrlT       got;
        logic [7:0] gotFlags;
        string      name;
        memFuncT    expMem;
        row      = rows[idx];
        got      = exBundle.ctrl;
        name     = rowName[idx];
        gotFlags = {got.branch, got.jump, got.regJump, got.memRead,
                    got.memWrite, got.memToReg, got.aluSrc, got.regWrite};
        // Only loads and stores touch memory, always a full word
        expMem   = (row.flags[4] || row.flags[3]) ? MEM_WORD : MEM_NONE;
        checkValue(name, "exValid", 32'(row.valid), 32'(exValid));
        checkValue(name, "aluOp", 32'(row.aluOp), 32'(got.aluOp));
        checkValue(name, "flags", 32'(row.flags), 32'(gotFlags));
        checkValue(name, "brCode", 32'(row.brCode), 32'(got.brCode));
        checkValue(name, "memFunc", 32'(expMem), 32'(got.memFunc));
        checkValue(name, "illegal", 32'(row.illegal), 32'(got.illegal));
        checkValue(name, "imm", row.imm, exBundle.imm);
        checkValue(name, "destAddr", 32'(row.dest), 32'(exBundle.destAddr));
        checkValue(name, "rsAddr", 32'(row.instr[25:21]), 32'(exBundle.rsAddr));
        checkValue(name, "rtAddr", 32'(row.instr[20:16]), 32'(exBundle.rtAddr));
        checkValue(name, "shamt", 32'(row.instr[10:6]), 32'(exBundle.shamt));
        checkValue(name, "offset", 32'(row.instr[15:0]), 32'(exBundle.offset));
        checkValue(name, "rsData", model[row.instr[25:21]], exBundle.rsData);
        checkValue(name, "rtData", model[row.instr[20:16]], exBundle.rtData);
    endtask

    task automatic preloadRegs();
        for (int r = 0; r < NUM_REGS; r++) begin
            @(posedge Clock);
            #1;
            wbEn   = 1'b1;
            wbAddr = 5'(r);
            wbData = $random(seed);
            // Register 0 keeps reading zero
            if (r != 0) begin
                model[r] = wbData;
            end
        end
        @(posedge Clock);
        #1;
        wbEn = 1'b0;
    endtask

    // Each row goes in back to back and comes out two edges later
    task automatic applyTable();
        for (int i = 0; i < rowCount + 2; i++) begin
            @(posedge Clock);
            #1;
            if (i >= 2) begin
                checkRow(i - 2);
            end
            if (i < rowCount) begin
                instr      = rows[i].instr;
                instrValid = rows[i].valid;
            end else begin
                instr      = '0;
                instrValid = 1'b0;
            end
        end
    endtask

    initial begin
        arstN      = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        wbEn       = 1'b0;
        wbAddr     = '0;
        wbData     = '0;
        seed       = 32'h4636_b069;
        checkCount = 0;
        errCount   = 0;
        rowCount   = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model[r] = '0;
        end
        buildTable();

        repeat (RESET_CYCLES) @(posedge Clock);
        #1;
        checkQuiet("reset held");
        arstN = 1'b1;
        @(posedge Clock);
        #1;
        checkQuiet("reset released");

        preloadRegs();
        applyTable();

        $display("checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the table did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/instrLatch.sv
verilog/ctrlDecoder.sv
verilog/regFile.sv
verilog/decodeUnit.sv
verilog/idExReg.sv
verilog/decodeTop.sv
verification/decodeCheck_assert.sv
verification/decodeTb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module decodeTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VdecodeTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -F -x -q '*** PASSED ***' sim.log; then
    exit 0
fi
exit 1
